// File: all.f
+incdir+.
dcache_addr_pkg.sv
dcache_req_pkg.sv
dcache_store_align.sv
dcache_way.sv
dcache_plru.sv
dcache_hit_resolve.sv
dcache_data_top.sv
tb_dcache.sv

// File: Makefile
# Verilator simulation of the data cache stage

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run tb_dcache, then check sim.log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f all.f -o sim_dcache
	./obj_dir/sim_dcache > sim.log 2>&1 || true
	@cat sim.log
	@grep -qx '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_dcache.sv
`include "dcache_defines.svh"

module tb_dcache;

	localparam int TIMEOUT = 40;

	// Way hit order for the LRU test where -1 marks a miss
	localparam int LRU_ORDER[8] = '{2, 0, -1, 3, -1, 1, 2, -1};

	typedef struct packed {
		logic root;
		logic low;
		logic high;
	} lru_tree_t;

	logic clk;
	logic reset;
	logic req_valid;
	dcache_req_pkg::dcache_req_t req;
	logic req_ready;
	logic fill_valid;
	dcache_req_pkg::fill_t fill;
	logic resp_valid;
	dcache_req_pkg::dcache_resp_t resp;

	integer seed;
	int errors;
	int tests_done;
	int start_errors;
	int wait_cycles;
	logic [3:0] next_id;
	dcache_addr_pkg::tag_t tag_a;
	dcache_addr_pkg::tag_t lru_tags[`DCACHE_WAYS];
	logic [`DCACHE_LINE_BITS - 1:0] line_a;

	// Reference model of the ways and the LRU trees
	logic [`DCACHE_LINE_BITS - 1:0] m_line[`DCACHE_WAYS][`DCACHE_SETS];
	dcache_addr_pkg::tag_t m_tag[`DCACHE_WAYS][`DCACHE_SETS];
	logic m_valid[`DCACHE_WAYS][`DCACHE_SETS];
	lru_tree_t m_tree[`DCACHE_SETS];

	// Model pipeline of lookup stage and expected response
	logic s1_valid;
	int s1_way;
	dcache_addr_pkg::set_idx_t s1_set;
	dcache_req_pkg::dcache_resp_t s1_resp;
	dcache_req_pkg::dcache_resp_t stage_resp;
	logic exp_valid;
	dcache_req_pkg::dcache_resp_t exp_resp;

	dcache_data_top DUT(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.fill_valid(fill_valid),
		.fill(fill),
		.resp_valid(resp_valid),
		.resp(resp));

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic dcache_addr_pkg::tag_t random_tag();
		return dcache_addr_pkg::tag_t'(rand32());
	endfunction

	function automatic logic [`DCACHE_LINE_BITS - 1:0] random_line();
		logic [`DCACHE_LINE_BITS - 1:0] line;
		line = '0;
		for (int i = 0; i < `DCACHE_LINE_WORDS; i++)
			line = {line[`DCACHE_LINE_BITS - 33:0], rand32()};
		return line;
	endfunction

	function automatic dcache_addr_pkg::line_addr_t make_addr(input dcache_addr_pkg::tag_t tag,
		input int set_idx, input int lane, input int offset);
		dcache_addr_pkg::line_addr_t a;
		a.tag = tag;
		a.set_idx = dcache_addr_pkg::set_idx_t'(set_idx);
		a.lane = dcache_addr_pkg::lane_idx_t'(lane);
		a.offset = dcache_addr_pkg::byte_off_t'(offset);
		return a;
	endfunction

	// Lane 0 is the most significant word of a line
	function automatic logic [31:0] line_word(input logic [`DCACHE_LINE_BITS - 1:0] line,
		input int lane);
		return line[(`DCACHE_LINE_WORDS - 1 - lane) * 32 +: 32];
	endfunction

	function automatic logic [31:0] merge_store(input logic [31:0] old_word,
		input dcache_req_pkg::access_size_t size, input int offset, input logic [31:0] value);
		logic [31:0] w;
		w = old_word;
		case (size)
			dcache_req_pkg::SIZE_BYTE:
				w[31 - 8 * offset -: 8] = value[7:0];
			dcache_req_pkg::SIZE_HALF:
			begin
				if (offset >= 2)
					w[15:0] = value[15:0];
				else
					w[31:16] = value[15:0];
			end
			default:
				w = value;
		endcase
		return w;
	endfunction

	function automatic lru_tree_t tree_update(input lru_tree_t t, input int way);
		lru_tree_t n;
		n = t;
		if (way < 2)
		begin
			n.root = 1'b1;
			n.low = (way == 0);
		end
		else
		begin
			n.root = 1'b0;
			n.high = (way == 2);
		end
		return n;
	endfunction

	function automatic int tree_victim(input lru_tree_t t);
		if (!t.root)
			return t.low ? 1 : 0;
		return t.high ? 3 : 2;
	endfunction

	// Hit check on the model state as it stands before this edge's writes
	function automatic void model_lookup();
		int way_hit;
		int lane;
		logic [31:0] old_word;
		dcache_addr_pkg::line_addr_t a;
		a = req.addr;
		lane = int'(a.lane);
		way_hit = -1;
		for (int w = 0; w < `DCACHE_WAYS; w++)
		begin
			if (m_valid[w][a.set_idx] && m_tag[w][a.set_idx] == a.tag)
				way_hit = w;
		end
		s1_resp.id = req.id;
		s1_resp.is_load = req.is_load;
		s1_resp.hit = (way_hit >= 0);
		s1_resp.load_word = '0;
		s1_resp.line_addr = {a.tag, a.set_idx, 4'b0000};
		s1_resp.victim = '0;
		if (way_hit >= 0)
		begin
			old_word = line_word(m_line[way_hit][a.set_idx], lane);
			s1_resp.load_word = old_word;
			if (!req.is_load)
				m_line[way_hit][a.set_idx][(`DCACHE_LINE_WORDS - 1 - lane) * 32 +: 32] =
					merge_store(old_word, req.size, int'(a.offset), req.store_value);
		end
		s1_set = a.set_idx;
		s1_way = way_hit;
		s1_valid = 1'b1;
	endfunction

	always @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s1_valid = 1'b0;
			exp_valid <= 1'b0;
			for (int s = 0; s < `DCACHE_SETS; s++)
			begin
				m_tree[s] = '0;
				for (int w = 0; w < `DCACHE_WAYS; w++)
					m_valid[w][s] = 1'b0;
			end
		end
		else
		begin
			// Victim comes from the tree before this edge's update
			exp_valid <= s1_valid;
			if (s1_valid)
			begin
				stage_resp = s1_resp;
				stage_resp.victim = dcache_addr_pkg::way_idx_t'(tree_victim(m_tree[s1_set]));
				exp_resp <= stage_resp;
			end

			// A fill wins the LRU update over a hit in the same cycle
			if (fill_valid)
				m_tree[fill.set_idx] = tree_update(m_tree[fill.set_idx], int'(fill.way));
			else if (s1_valid && s1_resp.hit)
				m_tree[s1_set] = tree_update(m_tree[s1_set], s1_way);

			s1_valid = 1'b0;
			if (fill_valid)
			begin
				m_line[fill.way][fill.set_idx] = fill.data;
				m_tag[fill.way][fill.set_idx] = fill.tag;
				m_valid[fill.way][fill.set_idx] = 1'b1;
			end
			else if (req_valid)
				model_lookup();
		end
	end

	assert property (@(posedge clk) disable iff (reset) req_ready == !fill_valid)
	else
	begin
		errors++;
		$display("Mismatch at %0t: req_ready does not follow fill_valid", $time);
	end

	assert property (@(posedge clk) disable iff (reset) resp_valid == exp_valid)
	else
	begin
		errors++;
		$display("Mismatch at %0t: resp_valid differs from the model", $time);
	end

	assert property (@(posedge clk) disable iff (reset)
		resp_valid |-> resp.id == exp_resp.id && resp.is_load == exp_resp.is_load)
	else
	begin
		errors++;
		$display("Mismatch at %0t: response id or load flag", $time);
	end

	assert property (@(posedge clk) disable iff (reset)
		resp_valid |-> resp.hit == exp_resp.hit)
	else
	begin
		errors++;
		$display("Mismatch at %0t: hit flag for request %0d", $time, exp_resp.id);
	end

	assert property (@(posedge clk) disable iff (reset)
		resp_valid |-> resp.load_word == exp_resp.load_word)
	else
	begin
		errors++;
		$display("Mismatch at %0t: load word for request %0d", $time, exp_resp.id);
	end

	assert property (@(posedge clk) disable iff (reset)
		resp_valid |-> resp.line_addr == exp_resp.line_addr)
	else
	begin
		errors++;
		$display("Mismatch at %0t: line address for request %0d", $time, exp_resp.id);
	end

	assert property (@(posedge clk) disable iff (reset)
		resp_valid |-> resp.victim == exp_resp.victim)
	else
	begin
		errors++;
		$display("Mismatch at %0t: victim way for request %0d", $time, exp_resp.id);
	end

	task automatic end_run();
		$display("Tests run: %0d, errors: %0d", tests_done, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		errors++;
		end_run();
	endtask

	task automatic finish_test(input string name, input int first_errors);
		tests_done++;
		$display("Test %0d %s: %0d errors", tests_done, name, errors - first_errors);
	endtask

	// Called on a falling edge and returns on the falling edge after acceptance
	task automatic issue_req(input logic is_load, input dcache_req_pkg::access_size_t size,
		input dcache_addr_pkg::line_addr_t addr, input logic [31:0] value, output int waited);
		logic accepted;
		waited = 0;
		accepted = 1'b0;
		req_valid = 1'b1;
		req.id = next_id;
		req.is_load = is_load;
		req.size = size;
		req.addr = addr;
		req.store_value = value;
		next_id = next_id + 4'd1;
		while (!accepted)
		begin
			@(posedge clk);
			if (req_ready)
				accepted = 1'b1;
			else if (waited >= TIMEOUT)
				report_timeout("request was never accepted");
			else
				waited++;
		end
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic issue_fill(input int way, input int set_idx, input dcache_addr_pkg::tag_t tag,
		input logic [`DCACHE_LINE_BITS - 1:0] data);
		fill_valid = 1'b1;
		fill.way = dcache_addr_pkg::way_idx_t'(way);
		fill.set_idx = dcache_addr_pkg::set_idx_t'(set_idx);
		fill.tag = tag;
		fill.data = data;
		@(negedge clk);
		fill_valid = 1'b0;
	endtask

	task automatic drain_pipeline();
		int waited;
		waited = 0;
		while (s1_valid || exp_valid || resp_valid)
		begin
			@(negedge clk);
			if (waited >= TIMEOUT)
				report_timeout("responses did not drain");
			waited++;
		end
	endtask

	initial
	begin
		seed = 68509;
		errors = 0;
		tests_done = 0;
		next_id = '0;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		fill_valid = 1'b0;
		fill = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Cold cache so every load misses
		start_errors = errors;
		repeat (3) @(negedge clk);
		for (int i = 0; i < 4; i++)
			issue_req(1'b1, dcache_req_pkg::SIZE_WORD, make_addr(random_tag(), i, i, 0), '0,
				wait_cycles);
		drain_pipeline();
		finish_test("cold misses", start_errors);

		start_errors = errors;
		tag_a = random_tag();
		line_a = random_line();
		issue_fill(2, 3, tag_a, line_a);
		for (int i = 0; i < `DCACHE_LINE_WORDS; i++)
			issue_req(1'b1, dcache_req_pkg::SIZE_WORD, make_addr(tag_a, 3, i, 0), '0,
				wait_cycles);
		drain_pipeline();
		finish_test("fill then load hits", start_errors);

		// Mixed store sizes followed by back-to-back loads of the merged words
		start_errors = errors;
		tag_a = random_tag();
		issue_fill(1, 5, tag_a, random_line());
		issue_req(1'b0, dcache_req_pkg::SIZE_BYTE, make_addr(tag_a, 5, 1, 2), rand32(), wait_cycles);
		issue_req(1'b0, dcache_req_pkg::SIZE_HALF, make_addr(tag_a, 5, 1, 0), rand32(), wait_cycles);
		issue_req(1'b0, dcache_req_pkg::SIZE_WORD, make_addr(tag_a, 5, 2, 0), rand32(), wait_cycles);
		issue_req(1'b0, dcache_req_pkg::SIZE_BYTE, make_addr(tag_a, 5, 2, 3), rand32(), wait_cycles);
		issue_req(1'b0, dcache_req_pkg::SIZE_HALF, make_addr(tag_a, 5, 3, 2), rand32(), wait_cycles);
		for (int i = 0; i < `DCACHE_LINE_WORDS; i++)
			issue_req(1'b1, dcache_req_pkg::SIZE_WORD, make_addr(tag_a, 5, i, 0), '0,
				wait_cycles);
		drain_pipeline();
		finish_test("store alignment", start_errors);

		// Missing stores must leave the resident line of another tag untouched
		start_errors = errors;
		tag_a = random_tag();
		issue_fill(3, 7, ~tag_a, random_line());
		issue_req(1'b0, dcache_req_pkg::SIZE_BYTE, make_addr(tag_a, 7, 2, 3), rand32(), wait_cycles);
		issue_req(1'b0, dcache_req_pkg::SIZE_WORD, make_addr(tag_a, 7, 1, 0), rand32(), wait_cycles);
		issue_req(1'b1, dcache_req_pkg::SIZE_WORD, make_addr(~tag_a, 7, 2, 0), '0, wait_cycles);
		issue_req(1'b1, dcache_req_pkg::SIZE_WORD, make_addr(~tag_a, 7, 1, 0), '0, wait_cycles);
		drain_pipeline();
		issue_fill(0, 7, tag_a, random_line());
		issue_req(1'b1, dcache_req_pkg::SIZE_WORD, make_addr(tag_a, 7, 2, 0), '0, wait_cycles);
		issue_req(1'b1, dcache_req_pkg::SIZE_WORD, make_addr(tag_a, 7, 1, 0), '0, wait_cycles);
		drain_pipeline();
		finish_test("store miss", start_errors);

		// Distinct low tag bits keep the four ways apart
		start_errors = errors;
		for (int i = 0; i < `DCACHE_WAYS; i++)
		begin
			lru_tags[i] = random_tag();
			lru_tags[i][1:0] = 2'(i);
			issue_fill(i, 9, lru_tags[i], random_line());
		end
		for (int i = 0; i < 8; i++)
		begin
			if (LRU_ORDER[i] < 0)
				issue_req(1'b1, dcache_req_pkg::SIZE_WORD,
					make_addr(lru_tags[0] ^ 24'h800000, 9, i % 4, 0), '0, wait_cycles);
			else
				issue_req(1'b1, dcache_req_pkg::SIZE_WORD,
					make_addr(lru_tags[LRU_ORDER[i]], 9, i % 4, 0), '0, wait_cycles);
		end
		drain_pipeline();
		finish_test("LRU victim order", start_errors);

		// A request held during three fill cycles
		start_errors = errors;
		fork
			issue_req(1'b1, dcache_req_pkg::SIZE_WORD, make_addr(lru_tags[1], 9, 2, 0), '0,
				wait_cycles);
			begin
				issue_fill(0, 11, random_tag(), random_line());
				issue_fill(1, 11, random_tag(), random_line());
				issue_fill(2, 11, random_tag(), random_line());
			end
		join
		assert (wait_cycles == 3)
		else
		begin
			errors++;
			$display("Mismatch at %0t: request waited %0d cycles, expected 3", $time, wait_cycles);
		end
		drain_pipeline();
		finish_test("fill back-pressure", start_errors);

		end_run();
	end

endmodule

// File: dcache_data_top.sv
`include "dcache_defines.svh"

module dcache_data_top(
	input clk,
	input reset,
	input logic req_valid,
	input dcache_req_pkg::dcache_req_t req,
	output logic req_ready,
	input logic fill_valid,
	input dcache_req_pkg::fill_t fill,
	output logic resp_valid,
	output dcache_req_pkg::dcache_resp_t resp);

	dcache_req_pkg::way_cmd_t cmd;
	dcache_req_pkg::fill_t fill_cmd;
	dcache_req_pkg::dcache_resp_t lookup_info;
	logic fill_cmd_valid;
	logic lookup_valid;
	logic [`DCACHE_WAYS - 1:0] way_hit;
	logic [31:0] way_word[`DCACHE_WAYS];

	dcache_store_align front_end(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.fill_valid(fill_valid),
		.fill(fill),
		.cmd(cmd),
		.fill_cmd_valid(fill_cmd_valid),
		.fill_cmd(fill_cmd),
		.lookup_valid(lookup_valid),
		.lookup_info(lookup_info));

	for (genvar i = 0; i < `DCACHE_WAYS; i++)
	begin : way_gen
		dcache_way #(.WAY_ID(i)) way(
			.clk(clk),
			.reset(reset),
			.cmd(cmd),
			.fill_cmd_valid(fill_cmd_valid),
			.fill_cmd(fill_cmd),
			.hit(way_hit[i]),
			.read_word(way_word[i]));
	end

	dcache_hit_resolve resolver(
		.clk(clk),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.lookup_info(lookup_info),
		.way_hit(way_hit),
		.way_word(way_word),
		.fill_cmd_valid(fill_cmd_valid),
		.fill_cmd(fill_cmd),
		.resp_valid(resp_valid),
		.resp(resp));

endmodule

// File: dcache_hit_resolve.sv
`include "dcache_defines.svh"

module dcache_hit_resolve(
	input clk,
	input reset,
	input logic lookup_valid,
	input dcache_req_pkg::dcache_resp_t lookup_info,
	input logic [`DCACHE_WAYS - 1:0] way_hit,
	input logic [31:0] way_word[`DCACHE_WAYS],
	input logic fill_cmd_valid,
	input dcache_req_pkg::fill_t fill_cmd,
	output logic resp_valid,
	output dcache_req_pkg::dcache_resp_t resp);

	dcache_addr_pkg::line_addr_t lookup_addr;
	dcache_addr_pkg::way_idx_t hit_way;
	dcache_addr_pkg::way_idx_t victim;
	dcache_addr_pkg::set_idx_t lru_access_set;
	dcache_addr_pkg::way_idx_t lru_access_way;
	dcache_req_pkg::dcache_resp_t resp_next;
	logic any_hit;
	logic lru_access_en;

	assign lookup_addr = lookup_info.line_addr;
	assign any_hit = |way_hit;

	// One-hot to index
	always_comb
	begin
		hit_way = '0;
		for (int i = 0; i < `DCACHE_WAYS; i++)
		begin
			if (way_hit[i])
				hit_way = dcache_addr_pkg::way_idx_t'(i);
		end
	end

	// Fill takes the LRU port when both arrive in one cycle
	assign lru_access_en = fill_cmd_valid || (lookup_valid && any_hit);
	assign lru_access_set = fill_cmd_valid ? fill_cmd.set_idx : lookup_addr.set_idx;
	assign lru_access_way = fill_cmd_valid ? fill_cmd.way : hit_way;

	dcache_plru plru(
		.clk(clk),
		.reset(reset),
		.access_en(lru_access_en),
		.access_set(lru_access_set),
		.access_way(lru_access_way),
		.lookup_set(lookup_addr.set_idx),
		.victim(victim));

	// Victim comes from the tree before this access updates it
	always_comb
	begin
		resp_next = lookup_info;
		resp_next.hit = any_hit;
		resp_next.load_word = any_hit ? way_word[hit_way] : '0;
		resp_next.victim = victim;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			resp_valid <= 1'b0;
		else
			resp_valid <= lookup_valid;
	end

	always_ff @(posedge clk)
	begin
		if (lookup_valid)
			resp <= resp_next;
	end

	// Tags in different ways never alias
	assert property (@(posedge clk) disable iff (reset)
		lookup_valid |-> $onehot0(way_hit));

endmodule

// File: dcache_plru.sv
`include "dcache_defines.svh"

module dcache_plru(
	input clk,
	input reset,
	input logic access_en,
	input dcache_addr_pkg::set_idx_t access_set,
	input dcache_addr_pkg::way_idx_t access_way,
	input dcache_addr_pkg::set_idx_t lookup_set,
	output dcache_addr_pkg::way_idx_t victim);

	typedef struct packed {
		logic root;
		logic low;
		logic high;
	} tree_t;

	tree_t tree[`DCACHE_SETS];
	tree_t lookup_tree;
	tree_t next_tree;

	// Turn the path to the accessed way away from it
	always_comb
	begin
		next_tree = tree[access_set];
		if (!access_way[1])
		begin
			next_tree.root = 1'b1;
			next_tree.low = !access_way[0];
		end
		else
		begin
			next_tree.root = 1'b0;
			next_tree.high = !access_way[0];
		end
	end

	// Victim follows the tree bits
	assign lookup_tree = tree[lookup_set];

	always_comb
	begin
		if (!lookup_tree.root)
			victim = lookup_tree.low ? 2'd1 : 2'd0;
		else
			victim = lookup_tree.high ? 2'd3 : 2'd2;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `DCACHE_SETS; i++)
				tree[i] <= '0;
		end
		else if (access_en)
			tree[access_set] <= next_tree;
	end

endmodule

// File: dcache_way.sv
`include "dcache_defines.svh"

module dcache_way #(
	parameter int WAY_ID = 0
)(
	input clk,
	input reset,
	input dcache_req_pkg::way_cmd_t cmd,
	input logic fill_cmd_valid,
	input dcache_req_pkg::fill_t fill_cmd,
	output logic hit,
	output logic [31:0] read_word);

	dcache_addr_pkg::tag_t tags[`DCACHE_SETS];
	logic [`DCACHE_LINE_BITS - 1:0] lines[`DCACHE_SETS];
	logic [`DCACHE_SETS - 1:0] line_valid;
	logic fill_this_way;
	logic tag_match;
	logic lookup_hit;
	logic store_en;
	logic [`DCACHE_LINE_BITS - 1:0] lookup_line;
	dcache_addr_pkg::lane_idx_t lane_slot;

	assign fill_this_way = fill_cmd_valid
		&& fill_cmd.way == dcache_addr_pkg::way_idx_t'(WAY_ID);

	// Hit check
	assign tag_match = tags[cmd.addr.set_idx] == cmd.addr.tag;
	assign lookup_hit = cmd.lookup_valid && line_valid[cmd.addr.set_idx] && tag_match;
	assign store_en = lookup_hit && !cmd.is_load;

	assign lookup_line = lines[cmd.addr.set_idx];
	assign lane_slot = dcache_addr_pkg::lane_idx_t'(`DCACHE_LINE_WORDS - 1) - cmd.addr.lane;

	// Tag and line storage with one write per cycle
	always_ff @(posedge clk)
	begin
		if (fill_this_way)
		begin
			tags[fill_cmd.set_idx] <= fill_cmd.tag;
			lines[fill_cmd.set_idx] <= fill_cmd.data;
		end
		else if (store_en)
		begin
			for (int b = 0; b < `DCACHE_LINE_BYTES; b++)
			begin
				if (cmd.store_mask[b])
					lines[cmd.addr.set_idx][b * 8 +: 8] <= cmd.store_data[b * 8 +: 8];
			end
		end
	end

	// Addressed word of this way for the resolver to pick
	always_ff @(posedge clk)
	begin
		read_word <= lookup_line[lane_slot * 32 +: 32];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			line_valid <= '0;
			hit <= 1'b0;
		end
		else
		begin
			if (fill_this_way)
				line_valid[fill_cmd.set_idx] <= 1'b1;

			hit <= lookup_hit;
		end
	end

endmodule

// File: dcache_store_align.sv
`include "dcache_defines.svh"

module dcache_store_align(
	input clk,
	input reset,
	input logic req_valid,
	input dcache_req_pkg::dcache_req_t req,
	output logic req_ready,
	input logic fill_valid,
	input dcache_req_pkg::fill_t fill,
	output dcache_req_pkg::way_cmd_t cmd,
	output logic fill_cmd_valid,
	output dcache_req_pkg::fill_t fill_cmd,
	output logic lookup_valid,
	output dcache_req_pkg::dcache_resp_t lookup_info);

	logic accept;
	logic [31:0] word_data;
	logic [3:0] word_mask;
	dcache_addr_pkg::lane_idx_t lane_slot;
	dcache_addr_pkg::line_addr_t line_base;

	// A fill owns the shared write path for its whole cycle
	assign req_ready = !fill_valid;
	assign accept = req_valid && req_ready;
	assign fill_cmd_valid = fill_valid;
	assign fill_cmd = fill;

	// Lane 0 sits in the top bits of the line
	assign lane_slot = dcache_addr_pkg::lane_idx_t'(`DCACHE_LINE_WORDS - 1) - req.addr.lane;

	// Big-endian placement, mask bit 3 is byte offset 0
	always_comb
	begin
		case (req.size)
			dcache_req_pkg::SIZE_BYTE:
			begin
				word_data = {4{req.store_value[7:0]}};
				word_mask = 4'b1000 >> req.addr.offset;
			end

			dcache_req_pkg::SIZE_HALF:
			begin
				word_data = {2{req.store_value[15:0]}};
				word_mask = req.addr.offset[1] ? 4'b0011 : 4'b1100;
			end

			dcache_req_pkg::SIZE_WORD:
			begin
				word_data = req.store_value;
				word_mask = 4'b1111;
			end

			default:
			begin
				word_data = req.store_value;
				word_mask = 4'b0000;
			end
		endcase
	end

	always_comb
	begin
		cmd.lookup_valid = accept;
		cmd.is_load = req.is_load;
		cmd.id = req.id;
		cmd.addr = req.addr;

		// Same word in every lane, the mask picks the target lane
		cmd.store_data = {`DCACHE_LINE_WORDS{word_data}};
		cmd.store_mask = '0;
		if (!req.is_load)
			cmd.store_mask[lane_slot * 4 +: 4] = word_mask;
	end

	always_comb
	begin
		line_base = req.addr;
		line_base.lane = '0;
		line_base.offset = '0;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			lookup_valid <= 1'b0;
		else
			lookup_valid <= accept;
	end

	// Hit, data and victim are filled in by the resolver
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			lookup_info.id <= req.id;
			lookup_info.is_load <= req.is_load;
			lookup_info.hit <= 1'b0;
			lookup_info.load_word <= '0;
			lookup_info.line_addr <= line_base;
			lookup_info.victim <= '0;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		accept && !req.is_load |-> cmd.store_mask != '0);

endmodule

// File: dcache_req_pkg.sv
`include "dcache_defines.svh"

package dcache_req_pkg;

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} access_size_t;

	// Scalar load or store from the requester
	typedef struct packed {
		logic [3:0] id;
		logic is_load;
		access_size_t size;
		dcache_addr_pkg::line_addr_t addr;
		logic [31:0] store_value;
	} dcache_req_t;

	// Lookup and store command broadcast to every way
	typedef struct packed {
		logic lookup_valid;
		logic is_load;
		logic [3:0] id;
		dcache_addr_pkg::line_addr_t addr;
		logic [`DCACHE_LINE_BITS - 1:0] store_data;
		logic [`DCACHE_LINE_BYTES - 1:0] store_mask;
	} way_cmd_t;

	// Whole line refill into a chosen way
	typedef struct packed {
		dcache_addr_pkg::way_idx_t way;
		dcache_addr_pkg::set_idx_t set_idx;
		dcache_addr_pkg::tag_t tag;
		logic [`DCACHE_LINE_BITS - 1:0] data;
	} fill_t;

	typedef struct packed {
		logic [3:0] id;
		logic is_load;
		logic hit;
		logic [31:0] load_word;
		logic [`DCACHE_ADDR_WIDTH - 1:0] line_addr;
		dcache_addr_pkg::way_idx_t victim;
	} dcache_resp_t;

endpackage

// File: dcache_addr_pkg.sv
`include "dcache_defines.svh"

package dcache_addr_pkg;

	typedef logic [`DCACHE_SET_BITS - 1:0] set_idx_t;
	typedef logic [`DCACHE_TAG_BITS - 1:0] tag_t;
	typedef logic [`DCACHE_WAY_BITS - 1:0] way_idx_t;

	// Word position inside a line
	typedef logic [`DCACHE_LANE_BITS - 1:0] lane_idx_t;

	// Byte position inside a word, 0 is the most significant byte
	typedef logic [1:0] byte_off_t;

	// Byte address split into its cache fields
	typedef struct packed {
		tag_t tag;
		set_idx_t set_idx;
		lane_idx_t lane;
		byte_off_t offset;
	} line_addr_t;

endpackage

// File: dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Cache geometry
`define DCACHE_WAYS 4
`define DCACHE_SETS 16
`define DCACHE_LINE_BYTES 16
`define DCACHE_ADDR_WIDTH 32

// Derived widths
`define DCACHE_LINE_WORDS (`DCACHE_LINE_BYTES / 4)
`define DCACHE_LINE_BITS (`DCACHE_LINE_BYTES * 8)
`define DCACHE_SET_BITS $clog2(`DCACHE_SETS)
`define DCACHE_WAY_BITS $clog2(`DCACHE_WAYS)
`define DCACHE_LANE_BITS $clog2(`DCACHE_LINE_WORDS)
`define DCACHE_TAG_BITS (`DCACHE_ADDR_WIDTH - `DCACHE_SET_BITS - `DCACHE_LANE_BITS - 2)

`endif
